// File: flist.f
+incdir+verilog
+incdir+verification
verilog/ckr_pkg.sv
verilog/sel_cfg_regs.sv
verilog/delay_pipe.sv
verilog/port_rule_check.sv
verilog/map_track.sv
verilog/data_check.sv
verilog/err_collect.sv
verilog/mem_checker_top.sv
verification/tb_mem_checker.sv

// File: verification/tb_cases.svh
// one scenario per new_case/end_case pair, ops are pushed as
// push_op(cycle, op, a, b, c) with cycle 0 being the sel_load cycle
// address 1000 splits into bank 4 row 166, 6143 into bank 5 row 1023

task automatic build_table();
  new_case("legal traffic", 1000, 7);
  push_op(0, OP_WR, 1000, 0, 1);
  push_op(0, OP_T1_WR, 4, 166, 1);
  push_op(0, OP_T2_WR, 4'hc, 166, 1);
  push_op(1, OP_RD, 1000, 0, 0);
  push_op(1, OP_T1_RD, 4, 166, 0);
  push_op(1, OP_T2_RD, 0, 166, 0);
  push_op(1, OP_T2_RD, 1, 166, 0);
  push_op(3, OP_T2_RET, 4'hc, 0, 1);
  push_op(4, OP_RET, 0, 1, 1);
  push_op(4, OP_T1_RET, 4, 0, 1);
  end_case('0, 0);

  new_case("wrong read bit", 1000, 7);
  push_op(0, OP_WR, 1000, 0, 1);
  push_op(1, OP_RD, 1000, 0, 0);
  push_op(4, OP_RET, 0, 1, 0);
  end_case(flag_bit(ERR_DOUT), 1);

  // the returned bit differs from the shadow, yet with valid low only ERR_VLD may rise
  new_case("read valid low", 1000, 7);
  push_op(0, OP_WR, 1000, 0, 0);
  push_op(1, OP_RD, 1000, 0, 0);
  push_op(4, OP_RET, 0, 0, 1);
  end_case(flag_bit(ERR_VLD), 1);

  // the previous shadow is known with bit 0, a new selection must drop it
  new_case("new selection forgets", 2345, 3);
  push_op(1, OP_RD, 2345, 0, 0);
  push_op(4, OP_RET, 0, 1, 1);
  end_case('0, 0);

  new_case("bank one port", 1000, 7);
  push_op(0, OP_T1_WR, 2, 5, 0);
  push_op(0, OP_T1_RD, 2, 5, 0);
  end_case(flag_bit(ERR_PORT), 1);

  new_case("twin write mismatch", 1000, 7);
  push_op(0, OP_T2_SKEW, 4'hc, 5, 0);
  end_case(flag_bit(ERR_TWIN), 1);

  new_case("remap row collision", 1000, 7);
  push_op(0, OP_T2_WR, 4'hc, 5, 0);
  push_op(0, OP_T2_RD, 0, 5, 0);
  end_case(flag_bit(ERR_COLLIDE), 1);

  new_case("write address range", 1000, 7);
  push_op(0, OP_WR, 6144, 0, 0);
  push_op(1, OP_WR, 8191, 0, 1);
  end_case(flag_bit(ERR_RANGE), 2);

  new_case("map entry mismatch", 6143, 31);
  push_op(0, OP_T2_WR, 4'hd, 1023, 1);
  push_op(1, OP_T2_RD, 1, 1023, 0);
  push_op(3, OP_T2_RET, 4'h9, 0, 1);
  end_case(flag_bit(ERR_MAP_READ), 1);

  new_case("spare bit mismatch", 6143, 31);
  push_op(0, OP_T2_WR, 4'hd, 1023, 1);
  push_op(1, OP_T2_RD, 0, 1023, 0);
  push_op(3, OP_T2_RET, 4'hd, 0, 0);
  end_case(flag_bit(ERR_SPARE_READ), 1);

  new_case("bank bit mismatch", 6143, 31);
  push_op(0, OP_T1_WR, 5, 1023, 0);
  push_op(1, OP_T1_RD, 5, 1023, 0);
  push_op(4, OP_T1_RET, 5, 0, 1);
  end_case(flag_bit(ERR_BANK_READ), 1);

  new_case("two faults in one cycle", 1000, 7);
  push_op(0, OP_T1_WR, 2, 5, 0);
  push_op(0, OP_T1_RD, 2, 5, 0);
  push_op(0, OP_WR, 6500, 0, 0);
  end_case(flag_bit(ERR_PORT) | flag_bit(ERR_RANGE), 2);

  new_case("clear after faults", 1000, 7);
  end_case('0, 0);
endtask

// File: verification/tb_mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module tb_mem_checker;

  import ckr_pkg::*;

  localparam int ADR_W  = `CKR_BITADDR;
  localparam int ROW_W  = `CKR_BITVROW;
  localparam int DAT_W  = `CKR_WIDTH;
  localparam int BIT_W  = `CKR_BITWDTH;
  localparam int NBANK  = `CKR_NUMVBNK;
  localparam int MAP_W  = `CKR_SDOUT_WIDTH;
  localparam int FLD_W  = MAP_W + DAT_W;
  localparam int CNT_W  = `CKR_ERR_CNT_W;
  localparam int PERIOD = 100;
  localparam int TAIL   = `CKR_DRAM_DELAY + 4;

  typedef enum int {
    OP_WR, OP_RD, OP_RET, OP_T1_WR, OP_T1_RD, OP_T1_RET,
    OP_T2_WR, OP_T2_SKEW, OP_T2_RD, OP_T2_RET
  } op_e;

  typedef struct packed {
    int  cyc;
    op_e op;
    int  a;
    int  b;
    int  c;
  } op_t;

  typedef struct packed {
    int         adr;
    int         bitn;
    int         first;
    int         n_ops;
    int         len;
    err_flags_t flags;
    int         count;
  } case_t;

  logic                     clk;
  logic                     rst;
  logic                     write;
  logic [ADR_W-1:0]         wr_adr;
  logic [DAT_W-1:0]         din;
  logic                     read;
  logic [ADR_W-1:0]         rd_adr;
  logic [DAT_W-1:0]         rd_dout;
  logic                     rd_vld;
  logic [NBANK-1:0]         t1_readA;
  logic [NBANK-1:0]         t1_writeA;
  logic [NBANK*ROW_W-1:0]   t1_addrA;
  logic [NBANK*DAT_W-1:0]   t1_dinA;
  logic [NBANK*DAT_W-1:0]   t1_doutA;
  logic [1:0]               t2_writeA;
  logic [2*ROW_W-1:0]       t2_addrA;
  logic [2*FLD_W-1:0]       t2_dinA;
  logic [1:0]               t2_readB;
  logic [2*ROW_W-1:0]       t2_addrB;
  logic [2*FLD_W-1:0]       t2_doutB;
  logic                     cfg_write;
  logic [ADR_W-1:0]         cfg_adr;
  logic [BIT_W-1:0]         cfg_bit;
  logic                     err_clr;
  err_flags_t               err_flags;
  logic [CNT_W-1:0]         err_count;

  op_t   op_tab[$];
  case_t case_tab[$];
  string case_name[$];
  case_t cur;
  string cur_name;
  int    sel_bit_now;
  int    pass_cnt;
  int    fail_cnt;
  bit    table_done;
  int    limit_ns;

  mem_checker_top DUT (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld),
    .t1_readA  (t1_readA),
    .t1_writeA (t1_writeA),
    .t1_addrA  (t1_addrA),
    .t1_dinA   (t1_dinA),
    .t1_doutA  (t1_doutA),
    .t2_writeA (t2_writeA),
    .t2_addrA  (t2_addrA),
    .t2_dinA   (t2_dinA),
    .t2_readB  (t2_readB),
    .t2_addrB  (t2_addrB),
    .t2_doutB  (t2_doutB),
    .cfg_write (cfg_write),
    .cfg_adr   (cfg_adr),
    .cfg_bit   (cfg_bit),
    .err_clr   (err_clr),
    .err_flags (err_flags),
    .err_count (err_count)
  );

  function automatic err_flags_t flag_bit(err_code_e e);
    err_flags_t f;
    f    = '0;
    f[e] = 1'b1;
    return f;
  endfunction

  task automatic new_case(string name, int adr, int bitn);
    cur_name  = name;
    cur       = '0;
    cur.adr   = adr;
    cur.bitn  = bitn;
    cur.first = op_tab.size();
  endtask

  task automatic push_op(int cyc, op_e op, int a, int b, int c);
    op_t o;
    o.cyc = cyc;
    o.op  = op;
    o.a   = a;
    o.b   = b;
    o.c   = c;
    op_tab.push_back(o);
    cur.n_ops++;
    if (cyc + 1 > cur.len)
      cur.len = cyc + 1;
  endtask

  task automatic end_case(err_flags_t flags, int count);
    cur.flags = flags;
    cur.count = count;
    case_tab.push_back(cur);
    case_name.push_back(cur_name);
  endtask

  `include "tb_cases.svh"

  // strobes go low and every data bus carries fresh noise
  task automatic clear_inputs();
    write     = 1'b0;
    wr_adr    = '0;
    din       = $urandom;
    read      = 1'b0;
    rd_adr    = '0;
    rd_dout   = $urandom;
    rd_vld    = 1'b0;
    t1_readA  = '0;
    t1_writeA = '0;
    t1_addrA  = '0;
    for (int b = 0; b < NBANK; b++) begin
      t1_dinA[b*DAT_W +: DAT_W]  = $urandom;
      t1_doutA[b*DAT_W +: DAT_W] = $urandom;
    end
    t2_writeA = '0;
    t2_addrA  = '0;
    t2_dinA   = (2*FLD_W)'({$urandom, $urandom, $urandom});
    t2_readB  = '0;
    t2_addrB  = '0;
    t2_doutB  = (2*FLD_W)'({$urandom, $urandom, $urandom});
    cfg_write = 1'b0;
    cfg_adr   = '0;
    cfg_bit   = '0;
    err_clr   = 1'b0;
  endtask

  task automatic apply_op(op_t o);
    logic [FLD_W-1:0] fld;
    int               sb;
    sb      = sel_bit_now;
    fld     = {MAP_W'(o.a), DAT_W'($urandom)};
    fld[sb] = (o.c != 0);
    case (o.op)
      OP_WR: begin
        write   = 1'b1;
        wr_adr  = ADR_W'(o.a);
        din[sb] = (o.c != 0);
      end
      OP_RD: begin
        read   = 1'b1;
        rd_adr = ADR_W'(o.a);
      end
      OP_RET: begin
        rd_vld      = (o.b != 0);
        rd_dout[sb] = (o.c != 0);
      end
      OP_T1_WR: begin
        t1_writeA[o.a]                = 1'b1;
        t1_addrA[o.a*ROW_W +: ROW_W]  = ROW_W'(o.b);
        t1_dinA[o.a*DAT_W + sb]       = (o.c != 0);
      end
      OP_T1_RD: begin
        t1_readA[o.a]                = 1'b1;
        t1_addrA[o.a*ROW_W +: ROW_W] = ROW_W'(o.b);
      end
      OP_T1_RET: begin
        t1_doutA[o.a*DAT_W + sb] = (o.c != 0);
      end
      OP_T2_WR, OP_T2_SKEW: begin
        t2_writeA = 2'b11;
        t2_addrA  = {ROW_W'(o.b), ROW_W'(o.b)};
        t2_dinA   = {fld, fld};
        // the second copy gets the selected data bit flipped
        if (o.op == OP_T2_SKEW)
          t2_dinA[FLD_W + sb] = !fld[sb];
      end
      OP_T2_RD: begin
        t2_readB[o.a]                = 1'b1;
        t2_addrB[o.a*ROW_W +: ROW_W] = ROW_W'(o.b);
      end
      OP_T2_RET: begin
        t2_doutB = {fld, fld};
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_case(int idx);
    case_t k;
    bit    ok;
    k  = case_tab[idx];
    ok = 1'b1;
    assert (err_flags === k.flags) else begin
      $display("Error err_flags expected %h got %h", k.flags, err_flags);
      ok = 1'b0;
    end
    assert (err_count === CNT_W'(k.count)) else begin
      $display("Error err_count expected %h got %h", CNT_W'(k.count), err_count);
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test %0d %s ok", idx, case_name[idx]);
    end else begin
      fail_cnt++;
      $display("test %0d %s failed", idx, case_name[idx]);
    end
  endtask

  // clear, load the selection, play the cycles, then let the pipes drain
  task automatic run_case(int idx);
    case_t k;
    k           = case_tab[idx];
    sel_bit_now = k.bitn;
    @(negedge clk);
    clear_inputs();
    err_clr = 1'b1;
    @(negedge clk);
    clear_inputs();
    cfg_write = 1'b1;
    cfg_adr   = ADR_W'(k.adr);
    cfg_bit   = BIT_W'(k.bitn);
    for (int cyc = 0; cyc < k.len; cyc++) begin
      @(negedge clk);
      clear_inputs();
      for (int i = k.first; i < k.first + k.n_ops; i++) begin
        if (op_tab[i].cyc == cyc)
          apply_op(op_tab[i]);
      end
    end
    repeat (TAIL) begin
      @(negedge clk);
      clear_inputs();
    end
    check_case(idx);
  endtask

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    wait (table_done);
    #(limit_ns);
    $display("timeout, the scenarios did not finish within %0d ns", limit_ns);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int max_len;
    void'($urandom(32'hc0ef));
    pass_cnt = 0;
    fail_cnt = 0;
    rst      = 1'b1;
    clear_inputs();
    build_table();
    // a row costs its cycles plus clear, load and the drain tail
    max_len = 0;
    foreach (case_tab[i]) begin
      if (case_tab[i].len + 2 + TAIL > max_len)
        max_len = case_tab[i].len + 2 + TAIL;
    end
    limit_ns   = case_tab.size() * max_len * PERIOD * 2;
    table_done = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (case_tab[i]) begin
      run_case(i);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ckr_consts.svh
`ifndef CKR_CONSTS_SVH
`define CKR_CONSTS_SVH

// user data word and the index of one bit within it
`define CKR_WIDTH 32
`define CKR_BITWDTH 5

// virtual banks, the spare bank is not counted here
`define CKR_NUMVBNK 6
`define CKR_BITVBNK 3

`define CKR_NUMVROW 1024
`define CKR_BITVROW 10

// user depth is banks times rows and is not a power of two
`define CKR_NUMADDR 6144
`define CKR_BITADDR 13

// a remap entry is a valid bit above a bank index
`define CKR_SDOUT_WIDTH 4

// read latencies of the remap table and of the banks
`define CKR_SRAM_DELAY 2
`define CKR_DRAM_DELAY 3

`define CKR_ERR_CNT_W 8

`endif

// File: verilog/ckr_pkg.sv
`default_nettype none

`include "ckr_consts.svh"

package ckr_pkg;

  // bit positions in the error flag vector
  typedef enum int unsigned {
    ERR_RANGE      = 0,
    ERR_PORT       = 1,
    ERR_TWIN       = 2,
    ERR_COLLIDE    = 3,
    ERR_MAP_READ   = 4,
    ERR_SPARE_READ = 5,
    ERR_BANK_READ  = 6,
    ERR_DOUT       = 7,
    ERR_VLD        = 8
  } err_code_e;

  typedef logic [ERR_VLD:ERR_RANGE] err_flags_t;

  // one remap table entry, bank is meaningful only while vld is set
  typedef struct packed {
    logic                    vld;
    logic [`CKR_BITVBNK-1:0] bank;
  } map_entry_t;

  // an expected bit and whether it is worth comparing
  typedef struct packed {
    logic known;
    logic data;
  } expect_t;

endpackage

`default_nettype wire

// File: verilog/data_check.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module data_check (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     sel_load,
  input  wire [`CKR_BITADDR-1:0]  select_addr,
  input  wire [`CKR_BITWDTH-1:0]  select_bit,
  input  wire                     write,
  input  wire [`CKR_BITADDR-1:0]  wr_adr,
  input  wire [`CKR_WIDTH-1:0]    din,
  input  wire                     read,
  input  wire [`CKR_BITADDR-1:0]  rd_adr,
  input  wire [`CKR_WIDTH-1:0]    rd_dout,
  input  wire                     rd_vld,
  output ckr_pkg::err_flags_t     data_err
);

  import ckr_pkg::*;

  logic    wr_hit;
  logic    rd_hit;
  logic    rd_hit_q;
  logic    shadow_known;
  logic    shadow_bit;
  expect_t exp_d;
  expect_t exp_q;

  assign wr_hit = write && (wr_adr == select_addr);
  assign rd_hit = read && (rd_adr == select_addr);

  // the last bit written through the user port, as the user sees it
  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_known <= 1'b0;
    end else if (wr_hit) begin
      shadow_known <= 1'b1;
    end else if (sel_load) begin
      shadow_known <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      shadow_bit <= din[select_bit];
    end
  end

  // sampled at the read, so a write in the same cycle is not yet seen
  assign exp_d.known = shadow_known;
  assign exp_d.data  = shadow_bit;

  delay_pipe #(.payload_t(expect_t), .DEPTH(`CKR_DRAM_DELAY)) u_exp_dly (
    .clk (clk),
    .rst (rst),
    .d   (exp_d),
    .q   (exp_q)
  );

  delay_pipe #(.payload_t(logic), .DEPTH(`CKR_DRAM_DELAY)) u_hit_dly (
    .clk (clk),
    .rst (rst),
    .d   (rd_hit),
    .q   (rd_hit_q)
  );

  always_comb begin
    data_err           = '0;
    data_err[ERR_VLD]  = rd_hit_q && !rd_vld;
    data_err[ERR_DOUT] = rd_hit_q && rd_vld && exp_q.known &&
                         (rd_dout[select_bit] != exp_q.data);
  end

endmodule

`default_nettype wire

// File: verilog/delay_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module delay_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      payload_t d,
  output payload_t q
);

  // one stage per cycle of latency, so DEPTH items can be in flight
  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/err_collect.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module err_collect (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        err_clr,
  input  wire ckr_pkg::err_flags_t   rule_err,
  input  wire ckr_pkg::err_flags_t   map_err,
  input  wire ckr_pkg::err_flags_t   data_err,
  output ckr_pkg::err_flags_t        err_flags,
  output logic [`CKR_ERR_CNT_W-1:0]  err_count
);

  import ckr_pkg::*;

  localparam int                CNT_W   = `CKR_ERR_CNT_W;
  localparam logic [CNT_W-1:0]  CNT_MAX = '1;

  err_flags_t       pulse;
  logic [CNT_W:0]   cnt_sum;

  assign pulse = rule_err | map_err | data_err;

  // one extra bit catches the carry that means saturation
  assign cnt_sum = {1'b0, err_count} + (CNT_W+1)'($countones(pulse));

  always_ff @(posedge clk) begin
    if (rst || err_clr) begin
      err_flags <= '0;
      err_count <= '0;
    end else begin
      err_flags <= err_flags | pulse;
      err_count <= cnt_sum[CNT_W] ? CNT_MAX : cnt_sum[CNT_W-1:0];
    end
  end

  a_count_monotonic: assert property (@(posedge clk) disable iff (rst)
    !err_clr |=> (err_count >= $past(err_count)));

endmodule

`default_nettype wire

// File: verilog/map_track.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module map_track (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire                                       sel_load,
  input  wire [`CKR_BITVBNK-1:0]                    select_bank,
  input  wire [`CKR_BITVROW-1:0]                    select_row,
  input  wire [`CKR_BITWDTH-1:0]                    select_bit,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_writeA,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_readA,
  input  wire [`CKR_NUMVBNK*`CKR_BITVROW-1:0]       t1_addrA,
  input  wire [`CKR_NUMVBNK*`CKR_WIDTH-1:0]         t1_dinA,
  input  wire [`CKR_NUMVBNK*`CKR_WIDTH-1:0]         t1_doutA,
  input  wire [1:0]                                 t2_writeA,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrA,
  input  wire [2*(`CKR_SDOUT_WIDTH+`CKR_WIDTH)-1:0] t2_dinA,
  input  wire [1:0]                                 t2_readB,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrB,
  input  wire [2*(`CKR_SDOUT_WIDTH+`CKR_WIDTH)-1:0] t2_doutB,
  output ckr_pkg::err_flags_t                       map_err
);

  import ckr_pkg::*;

  localparam int ROW_W = `CKR_BITVROW;
  localparam int DAT_W = `CKR_WIDTH;
  localparam int FLD_W = `CKR_SDOUT_WIDTH + `CKR_WIDTH;

  logic [ROW_W-1:0] t1_sel_addr;
  logic [DAT_W-1:0] t1_sel_din;
  logic [DAT_W-1:0] t1_sel_dout;
  logic             t1_wr_hit;
  logic             t1_rd_hit;
  logic             t2_wr_hit;
  logic             bank_known;
  logic             bank_bit;
  logic             map_known;
  map_entry_t       map_shadow;
  map_entry_t       map_dly;
  logic             spare_bit;
  expect_t          bank_exp_d;
  expect_t          bank_exp_q;
  logic [1:0]       map_bad;
  logic [1:0]       spare_bad;

  assign t1_sel_addr = t1_addrA[select_bank*ROW_W +: ROW_W];
  assign t1_sel_din  = t1_dinA[select_bank*DAT_W +: DAT_W];
  assign t1_sel_dout = t1_doutA[select_bank*DAT_W +: DAT_W];
  assign t1_wr_hit   = t1_writeA[select_bank] && (t1_sel_addr == select_row);
  assign t1_rd_hit   = t1_readA[select_bank] && (t1_sel_addr == select_row);

  // legal twin writes mirror port 0, so port 0 alone feeds the shadow
  assign t2_wr_hit = t2_writeA[0] && (t2_addrA[0 +: ROW_W] == select_row);

  // a write seen in the load cycle already targets the new selection
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_known <= 1'b0;
      map_known  <= 1'b0;
    end else begin
      if (t1_wr_hit) begin
        bank_known <= 1'b1;
      end else if (sel_load) begin
        bank_known <= 1'b0;
      end
      if (t2_wr_hit) begin
        map_known <= 1'b1;
      end else if (sel_load) begin
        map_known <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (t1_wr_hit) begin
      bank_bit <= t1_sel_din[select_bit];
    end
    if (t2_wr_hit) begin
      map_shadow <= t2_dinA[DAT_W +: `CKR_SDOUT_WIDTH];
      spare_bit  <= t2_dinA[select_bit];
    end
  end

  assign bank_exp_d.known = t1_rd_hit && bank_known;
  assign bank_exp_d.data  = bank_bit;

  delay_pipe #(.payload_t(expect_t), .DEPTH(`CKR_DRAM_DELAY)) u_bank_dly (
    .clk (clk),
    .rst (rst),
    .d   (bank_exp_d),
    .q   (bank_exp_q)
  );

  // both remap copies hold the same row, so one delayed entry serves both
  delay_pipe #(.payload_t(map_entry_t), .DEPTH(`CKR_SRAM_DELAY)) u_map_dly (
    .clk (clk),
    .rst (rst),
    .d   (map_shadow),
    .q   (map_dly)
  );

  for (genvar p = 0; p < 2; p++) begin : g_t2_rd
    expect_t          spare_d;
    expect_t          spare_q;
    map_entry_t       rd_map;
    logic [DAT_W-1:0] rd_dat;

    assign spare_d.known = t2_readB[p] && map_known &&
                           (t2_addrB[p*ROW_W +: ROW_W] == select_row);
    assign spare_d.data  = spare_bit;

    delay_pipe #(.payload_t(expect_t), .DEPTH(`CKR_SRAM_DELAY)) u_spare_dly (
      .clk (clk),
      .rst (rst),
      .d   (spare_d),
      .q   (spare_q)
    );

    assign rd_map       = t2_doutB[p*FLD_W+DAT_W +: `CKR_SDOUT_WIDTH];
    assign rd_dat       = t2_doutB[p*FLD_W +: DAT_W];
    assign map_bad[p]   = spare_q.known && (rd_map != map_dly);
    assign spare_bad[p] = spare_q.known && (rd_dat[select_bit] != spare_q.data);
  end

  always_comb begin
    map_err                 = '0;
    map_err[ERR_MAP_READ]   = |map_bad;
    map_err[ERR_SPARE_READ] = |spare_bad;
    map_err[ERR_BANK_READ]  = bank_exp_q.known &&
                              (t1_sel_dout[select_bit] != bank_exp_q.data);
  end

endmodule

`default_nettype wire

// File: verilog/mem_checker_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module mem_checker_top (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire                                       write,
  input  wire [`CKR_BITADDR-1:0]                    wr_adr,
  input  wire [`CKR_WIDTH-1:0]                      din,
  input  wire                                       read,
  input  wire [`CKR_BITADDR-1:0]                    rd_adr,
  input  wire [`CKR_WIDTH-1:0]                      rd_dout,
  input  wire                                       rd_vld,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_readA,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_writeA,
  input  wire [`CKR_NUMVBNK*`CKR_BITVROW-1:0]       t1_addrA,
  input  wire [`CKR_NUMVBNK*`CKR_WIDTH-1:0]         t1_dinA,
  input  wire [`CKR_NUMVBNK*`CKR_WIDTH-1:0]         t1_doutA,
  input  wire [1:0]                                 t2_writeA,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrA,
  input  wire [2*(`CKR_SDOUT_WIDTH+`CKR_WIDTH)-1:0] t2_dinA,
  input  wire [1:0]                                 t2_readB,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrB,
  input  wire [2*(`CKR_SDOUT_WIDTH+`CKR_WIDTH)-1:0] t2_doutB,
  input  wire                                       cfg_write,
  input  wire [`CKR_BITADDR-1:0]                    cfg_adr,
  input  wire [`CKR_BITWDTH-1:0]                    cfg_bit,
  input  wire                                       err_clr,
  output ckr_pkg::err_flags_t                       err_flags,
  output logic [`CKR_ERR_CNT_W-1:0]                 err_count
);

  import ckr_pkg::*;

  logic [`CKR_BITADDR-1:0] select_addr;
  logic [`CKR_BITVBNK-1:0] select_bank;
  logic [`CKR_BITVROW-1:0] select_row;
  logic [`CKR_BITWDTH-1:0] select_bit;
  logic                    sel_load;
  err_flags_t              rule_err;
  err_flags_t              map_err;
  err_flags_t              data_err;

  sel_cfg_regs u_sel_cfg_regs (
    .clk         (clk),
    .rst         (rst),
    .cfg_write   (cfg_write),
    .cfg_adr     (cfg_adr),
    .cfg_bit     (cfg_bit),
    .select_addr (select_addr),
    .select_bank (select_bank),
    .select_row  (select_row),
    .select_bit  (select_bit),
    .sel_load    (sel_load)
  );

  port_rule_check u_port_rule_check (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .t1_readA  (t1_readA),
    .t1_writeA (t1_writeA),
    .t1_addrA  (t1_addrA),
    .t2_writeA (t2_writeA),
    .t2_addrA  (t2_addrA),
    .t2_dinA   (t2_dinA),
    .t2_readB  (t2_readB),
    .t2_addrB  (t2_addrB),
    .rule_err  (rule_err)
  );

  map_track u_map_track (
    .clk         (clk),
    .rst         (rst),
    .sel_load    (sel_load),
    .select_bank (select_bank),
    .select_row  (select_row),
    .select_bit  (select_bit),
    .t1_writeA   (t1_writeA),
    .t1_readA    (t1_readA),
    .t1_addrA    (t1_addrA),
    .t1_dinA     (t1_dinA),
    .t1_doutA    (t1_doutA),
    .t2_writeA   (t2_writeA),
    .t2_addrA    (t2_addrA),
    .t2_dinA     (t2_dinA),
    .t2_readB    (t2_readB),
    .t2_addrB    (t2_addrB),
    .t2_doutB    (t2_doutB),
    .map_err     (map_err)
  );

  data_check u_data_check (
    .clk         (clk),
    .rst         (rst),
    .sel_load    (sel_load),
    .select_addr (select_addr),
    .select_bit  (select_bit),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .read        (read),
    .rd_adr      (rd_adr),
    .rd_dout     (rd_dout),
    .rd_vld      (rd_vld),
    .data_err    (data_err)
  );

  err_collect u_err_collect (
    .clk       (clk),
    .rst       (rst),
    .err_clr   (err_clr),
    .rule_err  (rule_err),
    .map_err   (map_err),
    .data_err  (data_err),
    .err_flags (err_flags),
    .err_count (err_count)
  );

endmodule

`default_nettype wire

// File: verilog/port_rule_check.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module port_rule_check (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire                                       write,
  input  wire [`CKR_BITADDR-1:0]                    wr_adr,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_readA,
  input  wire [`CKR_NUMVBNK-1:0]                    t1_writeA,
  input  wire [`CKR_NUMVBNK*`CKR_BITVROW-1:0]       t1_addrA,
  input  wire [1:0]                                 t2_writeA,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrA,
  input  wire [2*(`CKR_SDOUT_WIDTH+`CKR_WIDTH)-1:0] t2_dinA,
  input  wire [1:0]                                 t2_readB,
  input  wire [2*`CKR_BITVROW-1:0]                  t2_addrB,
  output ckr_pkg::err_flags_t                       rule_err
);

  import ckr_pkg::*;

  localparam int ROW_W = `CKR_BITVROW;
  localparam int FLD_W = `CKR_SDOUT_WIDTH + `CKR_WIDTH;

  logic port_hit;
  logic range_hit;
  logic twin_hit;
  logic collide_hit;

  // each bank is a single port macro
  assign port_hit = |(t1_readA & t1_writeA);

  always_comb begin
    range_hit = write && (wr_adr >= `CKR_NUMADDR);
    for (int b = 0; b < `CKR_NUMVBNK; b++) begin
      if (t1_writeA[b] && (t1_addrA[b*ROW_W +: ROW_W] >= `CKR_NUMVROW)) begin
        range_hit = 1'b1;
      end
    end
  end

  // the two remap copies are written as twins, port 1 never writes alone
  assign twin_hit = t2_writeA[1] &&
                    (!t2_writeA[0] ||
                     (t2_addrA[0 +: ROW_W] != t2_addrA[ROW_W +: ROW_W]) ||
                     (t2_dinA[0 +: FLD_W] != t2_dinA[FLD_W +: FLD_W]));

  // pseudo dual port copies cannot write and read one row in a cycle
  always_comb begin
    collide_hit = 1'b0;
    for (int p = 0; p < 2; p++) begin
      if (t2_writeA[p] && t2_readB[p] &&
          (t2_addrA[p*ROW_W +: ROW_W] == t2_addrB[p*ROW_W +: ROW_W])) begin
        collide_hit = 1'b1;
      end
    end
  end

  always_comb begin
    rule_err              = '0;
    rule_err[ERR_RANGE]   = range_hit;
    rule_err[ERR_PORT]    = port_hit;
    rule_err[ERR_TWIN]    = twin_hit;
    rule_err[ERR_COLLIDE] = collide_hit;
  end

  a_rule_scope: assert property (@(posedge clk) disable iff (rst)
    !(rule_err[ERR_MAP_READ] || rule_err[ERR_SPARE_READ] || rule_err[ERR_BANK_READ] ||
      rule_err[ERR_DOUT] || rule_err[ERR_VLD]));

endmodule

`default_nettype wire

// File: verilog/sel_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "ckr_consts.svh"

module sel_cfg_regs (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      cfg_write,
  input  wire [`CKR_BITADDR-1:0]   cfg_adr,
  input  wire [`CKR_BITWDTH-1:0]   cfg_bit,
  output logic [`CKR_BITADDR-1:0]  select_addr,
  output logic [`CKR_BITVBNK-1:0]  select_bank,
  output logic [`CKR_BITVROW-1:0]  select_row,
  output logic [`CKR_BITWDTH-1:0]  select_bit,
  output logic                     sel_load
);

  localparam int BANK_W = `CKR_BITVBNK;
  localparam int ROW_W  = `CKR_BITVROW;

  // the bank count is not a power of two, so the split is a real
  // modulo and divide done once per load and then held
  always_ff @(posedge clk) begin
    if (rst) begin
      select_addr <= '0;
      select_bank <= '0;
      select_row  <= '0;
      select_bit  <= '0;
    end else if (cfg_write) begin
      select_addr <= cfg_adr;
      select_bank <= BANK_W'(cfg_adr % `CKR_NUMVBNK);
      select_row  <= ROW_W'(cfg_adr / `CKR_NUMVBNK);
      select_bit  <= cfg_bit;
    end
  end

  // high in the first cycle the new selection is visible
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_load <= 1'b0;
    end else begin
      sel_load <= cfg_write;
    end
  end

  a_sel_range: assert property (@(posedge clk) disable iff (rst)
    sel_load |-> (select_addr < `CKR_NUMADDR) && (select_bank < `CKR_NUMVBNK) &&
                 (select_row < `CKR_NUMVROW));

endmodule

`default_nettype wire
